/* design/fp_div_consts.svh */
// ----------------------------------------------------------------------
// Format constants for the float32 divider: exponent bias, all-ones
// exponent, the canonical quiet NaN, the quotient width and the fixed
// request-to-acknowledge latency
// ----------------------------------------------------------------------

`ifndef FP_DIV_CONSTS_SVH
`define FP_DIV_CONSTS_SVH

// Exponent bias of the single-precision format
`define FP_BIAS 127

// Exponent code reserved for infinity and NaN
`define FP_EXP_ONES 255

// Quiet NaN returned for every invalid operation
`define FP_CANONICAL_NAN 32'h7fc00000

// Quotient bits developed by the divider
// 24 significand bits, one for the normalization shift, one for the underflow shift
`define FP_QUOT_BITS 26

// Rising edges from the accepting edge to the edge that raises ack
`define FP_DIV_LATENCY 28

`endif

/* design/fp_div_pkg.sv */
// ----------------------------------------------------------------------
// Types shared by the float32 divider: the float format, operand
// classes, exception flags, the Wishbone request and response words
// and the decoded operation passed between the stages
// ----------------------------------------------------------------------

`default_nettype none

package fp_div_pkg;

    // IEEE-754 single-precision number
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] significand;
    } float32_t;

    // Special-value class of one operand
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fp_class_t;

    // Exception flags returned with every result
    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    // Wishbone write data, the dividend sits in the upper word
    typedef struct packed {
        float32_t dividend;
        float32_t divisor;
    } fp_div_req_t;

    // Operation after decode
    // The exponent is biased and signed so that underflow shows up as a value <= 0
    typedef struct packed {
        logic               sign;
        logic signed [9:0]  exponent;
        logic [23:0]        dividend_sig;
        logic [23:0]        divisor_sig;
        fp_class_t          dividend_cls;
        fp_class_t          divisor_cls;
    } fp_decoded_t;

    // Wishbone read data
    typedef struct packed {
        float32_t  result;
        fp_flags_t flags;
    } fp_div_rsp_t;

endpackage

`default_nettype wire

/* design/fp_operand_decode.sv */
// ----------------------------------------------------------------------
// Decode stage: Wishbone request capture, busy tracking, operand
// classification, subnormal normalization, result sign and exponent
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module fp_operand_decode (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    cyc_i,
    input  wire logic                    stb_i,
    input  wire fp_div_pkg::fp_div_req_t req_i,
    input  wire logic                    done_i,
    output logic                         start_o,
    output fp_div_pkg::fp_decoded_t      op_o
);

    // Zero, infinity or NaN test on the raw encoding
    function automatic fp_div_pkg::fp_class_t classify(input fp_div_pkg::float32_t f);
        fp_div_pkg::fp_class_t c;
        c.is_zero = (f.exponent == 8'd0) && (f.significand == 23'd0);
        c.is_inf  = (f.exponent == 8'(`FP_EXP_ONES)) && (f.significand == 23'd0);
        c.is_nan  = (f.exponent == 8'(`FP_EXP_ONES)) && (f.significand != 23'd0);
        return c;
    endfunction

    // Leading zeros of a 24-bit significand, 24 when all bits are clear
    function automatic logic [4:0] clz24(input logic [23:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 5'd1;
                end
            end
        end
        return n;
    endfunction

    logic        busy_q;
    logic        accept;

    // Significands with the hidden bit restored, before and after the shift
    logic [23:0] a_sig;
    logic [23:0] b_sig;
    logic [4:0]  a_lz;
    logic [4:0]  b_lz;

    // Unbiased-free effective exponents, a subnormal counts as exponent 1
    logic signed [9:0] a_exp;
    logic signed [9:0] b_exp;

    // A request is taken only while idle, so there is never a second one in flight
    assign accept = cyc_i && stb_i && !busy_q;

    assign a_sig = {req_i.dividend.exponent != 8'd0, req_i.dividend.significand};
    assign b_sig = {req_i.divisor.exponent != 8'd0, req_i.divisor.significand};
    assign a_lz  = clz24(a_sig);
    assign b_lz  = clz24(b_sig);

    // Every position shifted left lowers the exponent by one
    assign a_exp = ((req_i.dividend.exponent == 8'd0) ? 10'sd1
                    : $signed({2'b00, req_i.dividend.exponent})) - $signed({5'b00000, a_lz});
    assign b_exp = ((req_i.divisor.exponent == 8'd0) ? 10'sd1
                    : $signed({2'b00, req_i.divisor.exponent})) - $signed({5'b00000, b_lz});

    // ------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------

    // Busy holds through the acknowledge cycle and drops on the edge after it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            start_o <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Operation register, stable for the whole operation
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_o.sign         <= req_i.dividend.sign ^ req_i.divisor.sign;
            op_o.exponent     <= a_exp - b_exp + $signed(10'(`FP_BIAS));
            op_o.dividend_sig <= a_sig << a_lz;
            op_o.divisor_sig  <= b_sig << b_lz;
            op_o.dividend_cls <= classify(req_i.dividend);
            op_o.divisor_cls  <= classify(req_i.divisor);
        end
    end

endmodule

`default_nettype wire

/* design/significand_divider.sv */
// ----------------------------------------------------------------------
// Execute stage: sequential non-restoring division of two normalized
// 24-bit significands, one quotient bit per clock, with a remainder
// correction that tells whether the quotient is exact
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module significand_divider (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      start_i,
    input  wire logic [23:0]               dividend_sig_i,
    input  wire logic [23:0]               divisor_sig_i,
    output logic [`FP_QUOT_BITS-1:0]       quotient_o,
    output logic                           remainder_nz_o,
    output logic                           done_o
);

    // Partial remainder, signed and kept already doubled for the next step
    logic [26:0] rem_q;
    logic [23:0] div_q;
    logic [4:0]  count_q;
    logic        running_q;

    logic [26:0] rem_step;
    logic [26:0] rem_fix;

    // Add when the remainder went negative, subtract otherwise
    // The first step always subtracts since the loaded dividend is positive
    assign rem_step = rem_q[26] ? rem_q + {3'b000, div_q} : rem_q - {3'b000, div_q};

    // Restore a negative final remainder, still in its doubled form
    assign rem_fix = rem_q + {2'b00, div_q, 1'b0};

    // Doubling does not change whether the remainder is zero
    assign remainder_nz_o = rem_q[26] ? (rem_fix != 27'd0) : (rem_q != 27'd0);

    // ------------------------------------------------------------------
    // Step counter and done pulse
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
            count_q   <= 5'd0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                count_q   <= 5'(`FP_QUOT_BITS);
            end else if (running_q) begin
                count_q <= count_q - 5'd1;
                // Last quotient bit lands on this edge
                if (count_q == 5'd1) begin
                    running_q <= 1'b0;
                    done_o    <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------

    // The dividend is below twice the divisor, so the first bit has weight 2^25
    // and the quotient equals dividend * 2^25 / divisor truncated
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q      <= {3'b000, dividend_sig_i};
            div_q      <= divisor_sig_i;
            quotient_o <= '0;
        end else if (running_q) begin
            // A non-negative new remainder means this quotient bit is one
            rem_q      <= {rem_step[25:0], 1'b0};
            quotient_o <= {quotient_o[`FP_QUOT_BITS-2:0], ~rem_step[26]};
        end
    end

endmodule

`default_nettype wire

/* design/fp_result_pack.sv */
// ----------------------------------------------------------------------
// Result stage: quotient normalization, overflow and underflow,
// special-value resolution, exception flags and the Wishbone
// acknowledge with its read data
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module fp_result_pack (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire fp_div_pkg::fp_decoded_t   op_i,
    input  wire logic [`FP_QUOT_BITS-1:0]  quotient_i,
    input  wire logic                      remainder_nz_i,
    input  wire logic                      exec_done_i,
    output fp_div_pkg::fp_div_rsp_t        rsp_o,
    output logic                           ack_o,
    output logic                           done_o
);

    // Normalized quotient, its leading one always in the top bit
    logic [`FP_QUOT_BITS-1:0] quot_norm;
    // Quotient after the denormalizing shift, and the part of it that survives
    logic [`FP_QUOT_BITS-1:0] quot_shift;
    logic [`FP_QUOT_BITS-1:0] quot_kept;
    logic signed [9:0]        exp_norm;
    logic [9:0]               shift_amt;
    logic                     bits_lost;
    logic                     a_nan;
    logic                     b_nan;
    fp_div_pkg::fp_div_rsp_t  rsp_d;
    logic                     ack_q;

    assign a_nan = op_i.dividend_cls.is_nan;
    assign b_nan = op_i.divisor_cls.is_nan;

    always_comb begin
        // A ratio below one leaves the top bit clear, so shift once and
        // borrow it back from the exponent
        if (quotient_i[`FP_QUOT_BITS-1]) begin
            quot_norm = quotient_i;
            exp_norm  = $signed(op_i.exponent);
        end else begin
            quot_norm = {quotient_i[`FP_QUOT_BITS-2:0], 1'b0};
            exp_norm  = $signed(op_i.exponent) - 10'sd1;
        end

        // Subnormal results move right by one minus the exponent
        shift_amt  = (exp_norm <= 10'sd0) ? 10'(10'sd1 - exp_norm) : 10'd0;
        quot_shift = quot_norm >> shift_amt;
        quot_kept  = {quot_shift[`FP_QUOT_BITS-1:2], 2'b00} << shift_amt;

        // Truncation loses the low two bits, the shifted-out bits and the remainder
        bits_lost = remainder_nz_i || (quot_kept != quot_norm);

        rsp_d               = '0;
        rsp_d.result.sign   = op_i.sign;

        if (a_nan || b_nan
            || (op_i.dividend_cls.is_zero && op_i.divisor_cls.is_zero)
            || (op_i.dividend_cls.is_inf && op_i.divisor_cls.is_inf)) begin
            rsp_d.result        = `FP_CANONICAL_NAN;
            rsp_d.flags.invalid = 1'b1;
        end else if (op_i.dividend_cls.is_inf) begin
            // Infinity over anything finite, zero included, stays infinite
            rsp_d.result.exponent = 8'(`FP_EXP_ONES);
        end else if (op_i.divisor_cls.is_zero) begin
            rsp_d.result.exponent  = 8'(`FP_EXP_ONES);
            rsp_d.flags.div_by_zero = 1'b1;
        end else if (op_i.dividend_cls.is_zero || op_i.divisor_cls.is_inf) begin
            // Signed zero, exponent and significand already clear
            rsp_d.result.exponent = 8'd0;
        end else if (exp_norm >= $signed(10'(`FP_EXP_ONES))) begin
            rsp_d.result.exponent = 8'(`FP_EXP_ONES);
            rsp_d.flags.overflow  = 1'b1;
            rsp_d.flags.inexact   = 1'b1;
        end else if (exp_norm <= 10'sd0) begin
            // Hidden bit was shifted below the top, so the field holds it
            rsp_d.result.significand = quot_shift[`FP_QUOT_BITS-2:2];
            rsp_d.flags.underflow    = 1'b1;
            rsp_d.flags.inexact      = bits_lost;
        end else begin
            rsp_d.result.exponent    = exp_norm[7:0];
            rsp_d.result.significand = quot_norm[`FP_QUOT_BITS-2:2];
            rsp_d.flags.inexact      = bits_lost;
        end
    end

    // ------------------------------------------------------------------
    // Response register and acknowledge
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= exec_done_i;
        end
    end

    // Read data holds until the next operation completes
    always_ff @(posedge clk_i) begin
        if (exec_done_i) begin
            rsp_o <= rsp_d;
        end
    end

    assign ack_o = ack_q;
    // Same pulse releases the decode stage one edge later
    assign done_o = ack_q;

endmodule

`default_nettype wire

/* design/fp_div_wb_top.sv */
// ----------------------------------------------------------------------
// Float32 divider with a Wishbone classic slave port
// Decode, execute and result stages wired in a chain
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module fp_div_wb_top (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    cyc_i,
    input  wire logic                    stb_i,
    input  wire fp_div_pkg::fp_div_req_t dat_i,
    output logic                         ack_o,
    output fp_div_pkg::fp_div_rsp_t      dat_o
);

    fp_div_pkg::fp_decoded_t  op;
    logic                     start;
    logic [`FP_QUOT_BITS-1:0] quotient;
    logic                     remainder_nz;
    logic                     exec_done;
    logic                     result_done;

    // Decode holds the operation steady until the result stage finishes
    fp_operand_decode u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .req_i   (dat_i),
        .done_i  (result_done),
        .start_o (start),
        .op_o    (op)
    );

    // Runs a fixed number of steps, special operands included
    significand_divider u_divider (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (start),
        .dividend_sig_i (op.dividend_sig),
        .divisor_sig_i  (op.divisor_sig),
        .quotient_o     (quotient),
        .remainder_nz_o (remainder_nz),
        .done_o         (exec_done)
    );

    fp_result_pack u_result (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .op_i           (op),
        .quotient_i     (quotient),
        .remainder_nz_i (remainder_nz),
        .exec_done_i    (exec_done),
        .rsp_o          (dat_o),
        .ack_o          (ack_o),
        .done_o         (result_done)
    );

endmodule

`default_nettype wire

/* tb/fp_div_checker.sv */
// ----------------------------------------------------------------------
// Response monitor for the float32 divider: expected values from the
// input file, per-test result lines, latency and protocol checks
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module fp_div_checker (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    cyc_i,
    input  wire logic                    stb_i,
    input  wire logic                    ack_i,
    input  wire fp_div_pkg::fp_div_rsp_t rsp_i,
    input  wire logic                    report_i,
    output int                           checked_o,
    output int                           errors_o
);

    string                   names[$];
    fp_div_pkg::fp_div_rsp_t expected[$];
    int                      passed;
    int                      edge_no;
    int                      accept_edge;
    // Model of the unit's busy state, taken from the bus alone
    logic                    busy;
    logic                    ack_seen;

    // Expected responses in file order, one per acknowledge
    task automatic read_expected();
        int                      fd;
        int                      n;
        string                   line;
        string                   name;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             r;
        logic [7:0]              f;
        fp_div_pkg::fp_div_rsp_t e;
        fd = $fopen("tb/fp_div_input.txt", "r");
        if (fd == 0) begin
            $display("checker could not open tb/fp_div_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", name, a, b, r, f);
                    if (n == 5) begin
                        e.result = r;
                        e.flags  = f[4:0];
                        names.push_back(name);
                        expected.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Compare one acknowledged response and print its line
    task automatic check_response(input int latency);
        logic ok;
        ok = 1'b1;
        if (checked_o >= expected.size()) begin
            $display("acknowledge arrived after all %0d tests were answered", expected.size());
            errors_o = errors_o + 1;
        end else begin
            if (rsp_i !== expected[checked_o]) begin
                $display("ERR %0s expected %h flags %h actual %h flags %h", names[checked_o],
                         expected[checked_o].result, expected[checked_o].flags,
                         rsp_i.result, rsp_i.flags);
                ok = 1'b0;
            end
            if (latency != `FP_DIV_LATENCY) begin
                $display("%0s acknowledge came %0d edges after acceptance instead of %0d",
                         names[checked_o], latency, `FP_DIV_LATENCY);
                ok = 1'b0;
            end
            if (ok) begin
                $display("pass %0s result %h flags %h", names[checked_o],
                         rsp_i.result, rsp_i.flags);
                passed = passed + 1;
            end else begin
                errors_o = errors_o + 1;
            end
            checked_o = checked_o + 1;
        end
    endtask

    initial begin
        read_expected();
    end

    // ------------------------------------------------------------------
    // Bus watch, sampled just before each rising edge takes effect
    // ------------------------------------------------------------------

    always @(posedge clk_i) begin
        logic accept;
        edge_no = edge_no + 1;
        if (!rst_n_i) begin
            busy      = 1'b0;
            ack_seen  = 1'b0;
            edge_no   = 0;
            passed    = 0;
            checked_o = 0;
            errors_o  = 0;
        end else begin
            // Acceptance sees busy as it was before this edge
            accept = cyc_i && stb_i && !busy;
            if (ack_i) begin
                if (ack_seen) begin
                    $display("acknowledge stayed high for more than one cycle");
                    errors_o = errors_o + 1;
                end else if (!busy) begin
                    $display("acknowledge arrived with no request in flight");
                    errors_o = errors_o + 1;
                end else begin
                    // Ack rose on the previous edge
                    check_response(edge_no - 1 - accept_edge);
                end
                busy = 1'b0;
            end
            if (accept) begin
                accept_edge = edge_no;
                busy        = 1'b1;
            end
            ack_seen = ack_i;
        end
    end

    always @(posedge report_i) begin
        $display("checked %0d responses, %0d passed, %0d failed", checked_o, passed, errors_o);
    end

endmodule

`default_nettype wire

/* tb/fp_div_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the float32 Wishbone divider: clock, reset, requests
// read from the input file with LFSR idle gaps, and the watchdog
// ----------------------------------------------------------------------

`default_nettype none

`include "fp_div_consts.svh"

module fp_div_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    // Quiet bus after the last test, any ack here is a stray one
    localparam int IDLE_CYCLES  = 40;

    logic                    clk;
    logic                    rst_n;
    logic                    cyc;
    logic                    stb;
    fp_div_pkg::fp_div_req_t req;
    logic                    ack;
    fp_div_pkg::fp_div_rsp_t rsp;
    logic                    report;
    int                      checked;
    int                      errors;

    fp_div_pkg::fp_div_req_t stim[$];
    logic [31:0]             lfsr;
    logic [1:0]              gap;

    fp_div_wb_top DUT (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .cyc_i   (cyc),
        .stb_i   (stb),
        .dat_i   (req),
        .ack_o   (ack),
        .dat_o   (rsp)
    );

    fp_div_checker u_checker (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .cyc_i     (cyc),
        .stb_i     (stb),
        .ack_i     (ack),
        .rsp_i     (rsp),
        .report_i  (report),
        .checked_o (checked),
        .errors_o  (errors)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1, the new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two fresh bits give an idle gap of 0 to 3 cycles
    task automatic draw_gap();
        lfsr   = lfsr_next(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        gap[1] = lfsr[0];
    endtask

    // Dividend and divisor columns of every test line
    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [7:0]  f;
        fd = $fopen("tb/fp_div_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/fp_div_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", name, a, b, r, f);
                    if (n == 5) begin
                        stim.push_back({a, b});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus, every bus change happens on a falling edge
    // ------------------------------------------------------------------

    initial begin
        rst_n  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        req    = '0;
        report = 1'b0;
        gap    = 2'd0;
        lfsr   = 32'h2bc9;
        read_stimulus();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < stim.size(); i++) begin
            cyc = 1'b1;
            stb = 1'b1;
            req = stim[i];
            @(negedge clk);
            while (!ack) begin
                @(negedge clk);
            end
            // With a zero gap the next request goes out in this same step
            cyc = 1'b0;
            stb = 1'b0;
            req = '0;
            draw_gap();
            repeat (gap) @(negedge clk);
        end
        repeat (IDLE_CYCLES) @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        if (stim.size() > 0 && errors == 0 && checked == stim.size()) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // ------------------------------------------------------------------
    // Watchdog, sized from the test count once the file is read
    // ------------------------------------------------------------------

    initial begin
        int limit;
        #1;
        limit = (stim.size() * (`FP_DIV_LATENCY + 6) + RESET_CYCLES + IDLE_CYCLES + 2)
                * CLK_PERIOD;
        #(limit);
        $display("timeout after %0d time units, the DUT stopped acknowledging", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* fp_div.f */
+incdir+design
design/fp_div_pkg.sv
design/fp_operand_decode.sv
design/significand_divider.sv
design/fp_result_pack.sv
design/fp_div_wb_top.sv
tb/fp_div_checker.sv
tb/fp_div_tb.sv

/* Makefile */
# Verilator build and run for the float32 Wishbone divider

SIM := obj_dir/Vfp_div_tb

# Build and run is the default goal
run: $(SIM)
	./$(SIM) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

# The binary is rebuilt only when a source, a header or the file list changes
$(SIM): fp_div.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --top-module fp_div_tb -f fp_div.f -o Vfp_div_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb/fp_div_input.txt */
# name dividend divisor expected_result expected_flags, all values in hex
# flags are {invalid, div_by_zero, overflow, underflow, inexact}
exact_6_by_3 40c00000 40400000 40000000 00
exact_neg_7p5_by_2p5 c0f00000 40200000 c0400000 00
inexact_1_by_3 3f800000 40400000 3eaaaaaa 01
inexact_2_by_7 40000000 40e00000 3e924924 01
subnormal_dividend 00400000 3a800000 05000000 00
subnormal_divisor 35800000 00200000 75800000 00
overflow_neg ff000000 00800000 ff800000 05
underflow_inexact 00800000 40400000 002aaaaa 03
underflow_exact 00800000 40000000 00400000 02
nan_operand 7fc00000 3f800000 7fc00000 10
zero_by_zero 00000000 80000000 7fc00000 10
inf_by_inf 7f800000 ff800000 7fc00000 10
x_by_zero c0000000 00000000 ff800000 08
inf_by_x 7f800000 c0400000 ff800000 00
zero_by_x 80000000 40400000 80000000 00
x_by_inf 40400000 ff800000 80000000 00
